//--- logic/axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_params.svh"

module axi_bridge (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  logic                    rd_req,
    input  cache_pkg::line_rd_req_t rd,
    output logic                    rd_rdy,
    output logic                    ret_valid,
    output logic [127:0]            ret_data,
    input  logic                    wr_req,
    input  cache_pkg::line_wr_req_t wr,
    output logic                    wr_rdy,
    output axi_pkg::axi_addr_t      ar,
    output logic                    arvalid,
    input  logic                    arready,
    input  axi_pkg::axi_rdata_t     r,
    input  logic                    rvalid,
    output logic                    rready,
    output axi_pkg::axi_addr_t      aw,
    output logic                    awvalid,
    input  logic                    awready,
    output axi_pkg::axi_wdata_t     w,
    output logic                    wvalid,
    input  logic                    wready,
    input  axi_pkg::axi_bresp_t     b,
    input  logic                    bvalid,
    output logic                    bready
);
    import axi_pkg::*;

    localparam int BEAT_BITS = $clog2(`LINE_WORDS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_AR,
        S_R,
        S_RET,
        S_AW,
        S_W,
        S_B
    } state_t;

    state_t                       state;
    axi_addr_t                    addr_q;
    logic [`LINE_WORDS-1:0][31:0] wbuf;
    logic [`LINE_WORDS-1:0][31:0] rbuf;
    logic [3:0]                   strb_q;
    logic                         single_q;
    logic [BEAT_BITS-1:0]         beat;
    logic                         last_beat;

    // writes first so a write-back goes out before its refill
    assign wr_rdy = (state == S_IDLE) && wr_req;
    assign rd_rdy = (state == S_IDLE) && rd_req && !wr_req;

    assign ar      = addr_q;
    assign aw      = addr_q;
    assign arvalid = (state == S_AR);
    assign awvalid = (state == S_AW);
    assign wvalid  = (state == S_W);
    assign rready  = (state == S_R);
    assign bready  = (state == S_B);

    assign last_beat = (beat == addr_q.len[BEAT_BITS-1:0]);
    assign w.data    = wbuf[beat];
    assign w.strb    = single_q ? strb_q : 4'hf;
    assign w.last    = last_beat;

    assign ret_valid = (state == S_RET);
    assign ret_data  = rbuf;

    always_ff @(posedge aclk) begin
        if (wr_rdy || rd_rdy) begin
            addr_q.addr  <= wr_rdy ? wr.addr : rd.addr;
            addr_q.id    <= 4'd0;
            addr_q.len   <= (wr_rdy ? wr.single : rd.single) ? 4'd0 : `AXI_BURST_LEN;
            addr_q.size  <= 3'd2;   // 4 bytes per beat
            addr_q.burst <= 2'b01;  // INCR
        end
        if (wr_rdy) begin
            wbuf     <= wr.data;
            strb_q   <= wr.strb;
            single_q <= wr.single;
        end
        if ((state == S_R) && rvalid) begin
            rbuf[beat] <= r.data;  // single read lands in word 0
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    beat <= '0;
                    if (wr_req) begin
                        state <= S_AW;
                    end else if (rd_req) begin
                        state <= S_AR;
                    end
                end
                S_AR: begin
                    if (arready) begin
                        state <= S_R;
                    end
                end
                S_R: begin
                    if (rvalid) begin
                        beat <= beat + 1'b1;
                        if (r.last) begin
                            state <= S_RET;
                        end
                    end
                end
                S_RET: state <= S_IDLE;
                S_AW: begin
                    if (awready) begin
                        state <= S_W;
                    end
                end
                S_W: begin
                    if (wready) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            state <= S_B;
                        end
                    end
                end
                S_B: begin
                    if (bvalid) begin
                        state <= S_IDLE;  // hold off reads until the write lands
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/axi_pkg.sv
`default_nettype none

package axi_pkg;

    // shared by AR and AW
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [3:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_addr_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_wdata_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } axi_rdata_t;

    typedef struct packed {
        logic [3:0] id;
        logic [1:0] resp;
    } axi_bresp_t;

endpackage

`default_nettype wire

//--- logic/cache_pkg.sv
`default_nettype none
`include "mem_params.svh"

package cache_pkg;

    typedef struct packed {
        logic [`TAG_BITS-1:0]    tag;
        logic [`INDEX_BITS-1:0]  index;
        logic [`OFFSET_BITS-1:0] offset;
    } line_view_t;

    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] rest;
    } seg_view_t;

    // same address word, cache view or segment view
    typedef union packed {
        line_view_t line;
        seg_view_t  segment;
    } cpu_addr_u;

    typedef struct packed {
        logic        op;    // 1 = store
        cpu_addr_u   addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        single;
    } line_rd_req_t;

    typedef struct packed {
        logic [31:0]  addr;
        logic [127:0] data;  // single write uses word 0
        logic [3:0]   strb;
        logic         single;
    } line_wr_req_t;

endpackage

`default_nettype wire

//--- logic/dcache.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_params.svh"

module dcache (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  logic                    valid,
    input  cache_pkg::cpu_req_t     req,
    output logic                    addr_ok,
    output logic                    data_ok,
    output logic [31:0]             rdata,
    output logic                    rd_req,
    output cache_pkg::line_rd_req_t rd,
    input  logic                    rd_rdy,
    input  logic                    ret_valid,
    input  logic [127:0]            ret_data,
    output logic                    wr_req,
    output cache_pkg::line_wr_req_t wr,
    input  logic                    wr_rdy
);
    import cache_pkg::*;

    localparam int SETS = 1 << `INDEX_BITS;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WB,
        S_RD_REQ,
        S_RD_WAIT,
        S_UNC_WR,
        S_UNC_DONE
    } state_t;

    state_t                       state;
    cpu_req_t                     req_q;
    logic                         uncached;
    logic [`INDEX_BITS-1:0]       idx;
    logic [`TAG_BITS-1:0]         tag;
    logic [`OFFSET_BITS-3:0]      word;
    logic                         hit;
    logic                         store_hit;
    logic                         refill;
    logic [31:0]                  merged;

    logic [`TAG_BITS-1:0]         tag_arr [SETS];
    logic [SETS-1:0]              valid_arr;
    logic [SETS-1:0]              dirty_arr;
    logic [`LINE_WORDS-1:0][31:0] data_arr [SETS];

    assign uncached  = (req_q.addr.segment.seg == `UNCACHED_SEG);
    assign idx       = req_q.addr.line.index;
    assign tag       = req_q.addr.line.tag;
    assign word      = req_q.addr.line.offset[`OFFSET_BITS-1:2];
    assign hit       = valid_arr[idx] && (tag_arr[idx] == tag);
    assign store_hit = (state == S_LOOKUP) && hit && req_q.op;
    assign refill    = (state == S_RD_WAIT) && ret_valid && !uncached;

    // byte merge of the store into the old word
    always_comb begin
        merged = data_arr[idx][word];
        for (int i = 0; i < 4; i++) begin
            if (req_q.wstrb[i]) begin
                merged[8*i +: 8] = req_q.wdata[8*i +: 8];
            end
        end
    end

    assign addr_ok = valid && (state == S_IDLE);
    assign data_ok = ((state == S_LOOKUP) && hit)
                  || ((state == S_RD_WAIT) && uncached && ret_valid)
                  || (state == S_UNC_DONE);
    assign rdata   = uncached ? ret_data[31:0] : data_arr[idx][word];

    assign rd_req    = (state == S_RD_REQ);
    assign rd.addr   = uncached ? req_q.addr : {tag, idx, {`OFFSET_BITS{1'b0}}};
    assign rd.single = uncached;

    // victim line or the single uncached word
    assign wr_req    = (state == S_WB) || (state == S_UNC_WR);
    assign wr.addr   = uncached ? req_q.addr : {tag_arr[idx], idx, {`OFFSET_BITS{1'b0}}};
    assign wr.data   = uncached ? {{(`LINE_WORDS*32-32){1'b0}}, req_q.wdata} : data_arr[idx];
    assign wr.strb   = uncached ? req_q.wstrb : 4'hf;
    assign wr.single = uncached;

    always_ff @(posedge aclk) begin
        if (addr_ok) begin
            req_q <= req;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (valid) begin
                        if (req.addr.segment.seg != `UNCACHED_SEG) begin
                            state <= S_LOOKUP;
                        end else if (req.op) begin
                            state <= S_UNC_WR;
                        end else begin
                            state <= S_RD_REQ;
                        end
                    end
                end
                S_LOOKUP: begin
                    if (hit) begin
                        state <= S_IDLE;
                    end else if (valid_arr[idx] && dirty_arr[idx]) begin
                        state <= S_WB;  // evict first
                    end else begin
                        state <= S_RD_REQ;
                    end
                end
                S_WB: begin
                    if (wr_rdy) begin
                        state <= S_RD_REQ;
                    end
                end
                S_RD_REQ: begin
                    if (rd_rdy) begin
                        state <= S_RD_WAIT;
                    end
                end
                S_RD_WAIT: begin
                    if (ret_valid) begin
                        state <= uncached ? S_IDLE : S_LOOKUP;  // retry after refill
                    end
                end
                S_UNC_WR: begin
                    if (wr_rdy) begin
                        state <= S_UNC_DONE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_arr <= '0;
            dirty_arr <= '0;
        end else if (store_hit) begin
            dirty_arr[idx] <= 1'b1;
        end else if (refill) begin
            valid_arr[idx] <= 1'b1;
            dirty_arr[idx] <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (store_hit) begin
            data_arr[idx][word] <= merged;
        end
        if (refill) begin
            data_arr[idx] <= ret_data;
            tag_arr[idx]  <= tag;
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// line geometry
`define LINE_WORDS    4
`define INDEX_BITS    3
`define OFFSET_BITS   4
`define TAG_BITS      25

// kseg1 style window, no cache
`define UNCACHED_SEG  3'b101

// arlen/awlen of a full line burst
`define AXI_BURST_LEN 4'd3

`endif

//--- logic/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                valid,
    input  cache_pkg::cpu_req_t req,
    output logic                addr_ok,
    output logic                data_ok,
    output logic [31:0]         rdata,
    output axi_pkg::axi_addr_t  ar,
    output logic                arvalid,
    input  logic                arready,
    input  axi_pkg::axi_rdata_t r,
    input  logic                rvalid,
    output logic                rready,
    output axi_pkg::axi_addr_t  aw,
    output logic                awvalid,
    input  logic                awready,
    output axi_pkg::axi_wdata_t w,
    output logic                wvalid,
    input  logic                wready,
    input  axi_pkg::axi_bresp_t b,
    input  logic                bvalid,
    output logic                bready
);
    import cache_pkg::*;

    // cache to bridge
    logic         rd_req;
    line_rd_req_t rd;
    logic         rd_rdy;
    logic         ret_valid;
    logic [127:0] ret_data;
    logic         wr_req;
    line_wr_req_t wr;
    logic         wr_rdy;

    dcache u_dcache (.*);

    axi_bridge u_bridge (.*);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Result: FAILED"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mem_subsys_tb -Mdir obj_dir -o mem_subsys_sim -f sources.f
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/mem_subsys_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

//--- sources.f
+incdir+logic
logic/axi_pkg.sv
logic/cache_pkg.sv
logic/dcache.sv
logic/axi_bridge.sv
logic/mem_subsys_top.sv
tb/mem_subsys_chk.sv
tb/mem_subsys_tb.sv

//--- tb/mem_subsys_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_chk (
    input logic                aclk,
    input logic                rst_n,
    input axi_pkg::axi_addr_t  ar,
    input logic                arvalid,
    input logic                arready,
    input axi_pkg::axi_addr_t  aw,
    input logic                awvalid,
    input logic                awready,
    input axi_pkg::axi_wdata_t w,
    input logic                wvalid,
    input logic                wready
);
    logic [3:0] awlen_q;
    logic [3:0] wbeat;  // W beats since the last AW

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            awlen_q <= '0;
            wbeat   <= '0;
        end else if (awvalid && awready) begin
            awlen_q <= aw.len;
            wbeat   <= '0;
        end else if (wvalid && wready) begin
            wbeat <= wbeat + 4'd1;
        end
    end

    ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("AR dropped or changed before arready");

    aw_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("AW dropped or changed before awready");

    w_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("W dropped or changed before wready");

    wlast_pos: assert property (@(posedge aclk) disable iff (!rst_n)
        wvalid |-> (w.last == (wbeat == awlen_q)))
        else $error("wlast does not match awlen");

    ar_aw_excl: assert property (@(posedge aclk) disable iff (!rst_n)
        !(arvalid && awvalid))
        else $error("arvalid and awvalid high together");

endmodule

bind axi_bridge mem_subsys_chk u_chk (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .ar      (ar),
    .arvalid (arvalid),
    .arready (arready),
    .aw      (aw),
    .awvalid (awvalid),
    .awready (awready),
    .w       (w),
    .wvalid  (wvalid),
    .wready  (wready)
);

`default_nettype wire

//--- tb/mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_params.svh"

module mem_subsys_tb;
    import axi_pkg::*;
    import cache_pkg::*;

    localparam int MEM_WORDS = 1024;
    localparam int TIMEOUT   = 200;

    logic                aclk;
    logic                rst_n;
    logic                valid;
    cpu_req_t            req;
    logic                addr_ok;
    logic                data_ok;
    logic [31:0]         rdata;
    axi_addr_t           ar;
    logic                arvalid;
    logic                arready;
    axi_rdata_t          r;
    logic                rvalid;
    logic                rready;
    axi_addr_t           aw;
    logic                awvalid;
    logic                awready;
    axi_wdata_t          w;
    logic                wvalid;
    logic                wready;
    axi_bresp_t          b;
    logic                bvalid;
    logic                bready;

    logic [31:0]            mem     [MEM_WORDS];  // what the bus sees
    logic [31:0]            ref_mem [MEM_WORDS];  // what the CPU should see
    logic [31:0]            w_beat      [`LINE_WORDS];
    logic [3:0]             w_strb_beat [`LINE_WORDS];
    logic [`LINE_WORDS-1:0] w_last_mask;
    axi_addr_t              ar_last;
    axi_addr_t              aw_last;
    int                     ar_cnt;
    int                     aw_cnt;
    int                     w_cnt;
    int                     cyc = 0;
    int                     last_lat;
    logic [31:0]            lfsr;

    mem_subsys_top dut0 (.*);

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    always @(posedge aclk) cyc <= cyc + 1;

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic abort_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    endtask

    // taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // slave stalls on AR, AW and W now and then
    initial begin : ready_gen
        arready = 1'b1;
        awready = 1'b1;
        wready  = 1'b1;
        forever begin
            @(posedge aclk);
            arready <= (cyc % 3 != 0);
            awready <= (cyc % 5 != 2);
            wready  <= (cyc % 4 != 1);
        end
    end

    // AXI read side, one burst at a time
    initial begin : read_slave
        int         n;
        axi_addr_t  a;
        logic [3:0] bt;
        forever begin
            @(negedge aclk);
            if (arvalid && arready) begin
                a       = ar;
                ar_last = ar;
                ar_cnt++;
                @(posedge aclk);
                bt = 4'd0;
                do begin
                    rvalid <= 1'b1;
                    r <= '{id: 4'd0, data: mem[a.addr[11:2] + {6'd0, bt}], resp: 2'b00,
                           last: (bt == a.len)};
                    n = 0;
                    @(negedge aclk);
                    while (!rready) begin
                        n++;
                        if (n > TIMEOUT) abort_timeout("rready");
                        @(negedge aclk);
                    end
                    @(posedge aclk);
                    bt++;
                end while (bt <= a.len);
                rvalid <= 1'b0;
            end
        end
    end

    initial begin : write_slave
        int         n;
        axi_addr_t  a;
        logic [3:0] bt;
        logic [9:0] wi;
        forever begin
            @(negedge aclk);
            if (awvalid && awready) begin
                a           = aw;
                aw_last     = aw;
                w_last_mask = '0;
                aw_cnt++;
                bt = 4'd0;
                do begin
                    n = 0;
                    @(negedge aclk);
                    while (!(wvalid && wready)) begin
                        n++;
                        if (n > TIMEOUT) abort_timeout("W beat");
                        @(negedge aclk);
                    end
                    wi                     = a.addr[11:2] + {6'd0, bt};
                    w_beat[bt[1:0]]        = w.data;
                    w_strb_beat[bt[1:0]]   = w.strb;
                    w_last_mask[bt[1:0]]   = w.last;
                    for (int i = 0; i < 4; i++) begin
                        if (w.strb[i]) mem[wi][8*i +: 8] = w.data[8*i +: 8];
                    end
                    w_cnt++;
                    @(posedge aclk);  // wready is high, beat taken here
                    bt++;
                end while (bt <= a.len);
                bvalid <= 1'b1;
                b      <= '{id: 4'd0, resp: 2'b00};
                n = 0;
                @(negedge aclk);
                while (!bready) begin
                    n++;
                    if (n > TIMEOUT) abort_timeout("bready");
                    @(negedge aclk);
                end
                @(posedge aclk);
                bvalid <= 1'b0;
            end
        end
    end

    // one CPU request, returns the read word and sets last_lat
    task automatic cpu_access(input logic op, input logic [31:0] addr, input logic [3:0] strb,
                              input logic [31:0] wdata, output logic [31:0] data);
        int n;
        int t_addr;
        @(posedge aclk);
        valid <= 1'b1;
        req   <= {op, addr, strb, wdata};
        n = 0;
        @(negedge aclk);
        while (!addr_ok) begin
            n++;
            if (n > TIMEOUT) abort_timeout("addr_ok");
            @(negedge aclk);
        end
        t_addr = cyc;
        @(posedge aclk);
        valid <= 1'b0;
        n = 0;
        @(negedge aclk);
        while (!data_ok) begin
            n++;
            if (n > TIMEOUT) abort_timeout("data_ok");
            @(negedge aclk);
        end
        last_lat = cyc - t_addr;
        data     = rdata;
    endtask

    task automatic load_check(input logic [31:0] addr, input string name);
        logic [31:0] d;
        cpu_access(1'b0, addr, 4'h0, 32'h0, d);
        check_eq(name, d, ref_mem[addr[11:2]]);
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [3:0] strb,
                              input logic [31:0] data);
        logic [31:0] d;
        cpu_access(1'b1, addr, strb, data, d);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) ref_mem[addr[11:2]][8*i +: 8] = data[8*i +: 8];
        end
    endtask

    task automatic test_reset();
        @(negedge aclk);
        check_eq("arvalid", 32'(arvalid), 32'd0);
        check_eq("awvalid", 32'(awvalid), 32'd0);
        check_eq("wvalid", 32'(wvalid), 32'd0);
        check_eq("data_ok", 32'(data_ok), 32'd0);
        check_eq("addr_ok", 32'(addr_ok), 32'd0);
        check_eq("rready", 32'(rready), 32'd0);
        check_eq("bready", 32'(bready), 32'd0);
    endtask

    task automatic test_read_miss_hit();
        int ar0;
        ar0 = ar_cnt;
        load_check(32'h0000_0124, "rdata miss");
        check_eq("ar count", ar_cnt, ar0 + 1);
        check_eq("arlen", 32'(ar_last.len), 32'd3);
        check_eq("arsize", 32'(ar_last.size), 32'd2);
        check_eq("arburst", 32'(ar_last.burst), 32'd1);
        check_eq("arid", 32'(ar_last.id), 32'd0);
        check_eq("araddr", ar_last.addr, 32'h0000_0120);
        load_check(32'h0000_012c, "rdata hit");
        check_eq("ar count", ar_cnt, ar0 + 1);
        check_eq("hit latency", last_lat, 32'd1);
    endtask

    task automatic test_store_hit();
        logic [31:0] old;
        logic [31:0] d;
        int          ar0;
        int          aw0;
        old = ref_mem[10'h049];
        ar0 = ar_cnt;
        aw0 = aw_cnt;
        store_word(32'h0000_0124, 4'b0101, 32'ha1b2_c3d4);
        check_eq("store latency", last_lat, 32'd1);
        cpu_access(1'b0, 32'h0000_0124, 4'h0, 32'h0, d);
        check_eq("merged rdata", d, {old[31:24], 8'hb2, old[15:8], 8'hd4});
        check_eq("ar count", ar_cnt, ar0);
        check_eq("aw count", aw_cnt, aw0);
    endtask

    // same index as 0x120, other tag
    task automatic test_dirty_evict();
        int ar0;
        int aw0;
        int w0;
        ar0 = ar_cnt;
        aw0 = aw_cnt;
        w0  = w_cnt;
        load_check(32'h0000_0524, "rdata after evict");
        check_eq("aw count", aw_cnt, aw0 + 1);
        check_eq("awaddr", aw_last.addr, 32'h0000_0120);
        check_eq("awlen", 32'(aw_last.len), 32'd3);
        check_eq("awid", 32'(aw_last.id), 32'd0);
        check_eq("w count", w_cnt, w0 + 4);
        check_eq("wlast", 32'(w_last_mask), 32'h8);
        for (int i = 0; i < 4; i++) begin
            check_eq("wdata", w_beat[i], ref_mem[10'h048 + 10'(i)]);
            check_eq("wstrb", 32'(w_strb_beat[i]), 32'hf);
            check_eq("memory", mem[10'h048 + 10'(i)], ref_mem[10'h048 + 10'(i)]);
        end
        check_eq("ar count", ar_cnt, ar0 + 1);
        check_eq("araddr", ar_last.addr, 32'h0000_0520);
    endtask

    task automatic test_uncached();
        int ar0;
        int aw0;
        ar0 = ar_cnt;
        aw0 = aw_cnt;
        load_check(32'ha000_0c40, "uncached rdata");
        check_eq("ar count", ar_cnt, ar0 + 1);
        check_eq("arlen", 32'(ar_last.len), 32'd0);
        check_eq("araddr", ar_last.addr, 32'ha000_0c40);
        load_check(32'ha000_0c40, "uncached rdata again");
        check_eq("ar count", ar_cnt, ar0 + 2);
        store_word(32'ha000_0c44, 4'b0011, 32'h5566_7788);
        load_check(32'ha000_0c44, "uncached readback");  // also waits out the B response
        check_eq("aw count", aw_cnt, aw0 + 1);
        check_eq("awlen", 32'(aw_last.len), 32'd0);
        check_eq("awaddr", aw_last.addr, 32'ha000_0c44);
        check_eq("wstrb", 32'(w_strb_beat[0]), 32'h3);
        check_eq("wlast", 32'(w_last_mask), 32'h1);
    endtask

    task automatic test_random();
        logic [31:0] sel;
        logic [31:0] off;
        logic [31:0] op;
        logic [31:0] strb;
        logic [31:0] data;
        logic [31:0] addr;
        for (int i = 0; i < 40; i++) begin
            sel = rand_bits(1);
            off = rand_bits(7);
            op  = rand_bits(1);
            if (sel[0]) begin
                addr = 32'ha000_0c00 + {26'd0, off[3:0], 2'b00};
            end else begin
                addr = {23'd0, off[6:0], 2'b00};  // 4 tags over all 8 lines
            end
            if (op[0]) begin
                strb = rand_bits(4);
                data = rand_bits(32);
                store_word(addr, strb[3:0], data);
            end else begin
                load_check(addr, "random rdata");
            end
        end
    endtask

    initial begin
        lfsr    = 32'h1cfa1098;
        rst_n   = 1'b0;
        valid   = 1'b0;
        req     = '0;
        rvalid  = 1'b0;
        r       = '0;
        bvalid  = 1'b0;
        b       = '0;
        ar_cnt  = 0;
        aw_cnt  = 0;
        w_cnt   = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = {i[15:0] ^ 16'hc3a5, ~i[15:0]};
            ref_mem[i] = mem[i];
        end
        repeat (3) @(posedge aclk);
        rst_n <= 1'b1;
        test_reset();
        test_read_miss_hit();
        test_store_hit();
        test_dirty_evict();
        test_uncached();
        test_random();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
